/* files.f */
pll_pkg.sv
la_pll.sv
pll_freq_meter.sv
pll_status_resp.sv
pll_cmd_decoder.sv
pll_subsys_top.sv
tb_pll_subsys.sv

/* la_pll.sv */
// cycle based pll model in the clk domain
// rational accumulator giving divfb / (divin * divout) ticks per clk
// bypass path and lock timer
module la_pll #(
   parameter int LOCK_CYCLES = 32                       // settling time after relock
) (
   input  logic              clk,
   input  logic              rst,
   input  pll_pkg::pll_cfg_t cfg,
   input  logic              relock,                    // restart accumulator and lock timer
   output logic              tick,                      // one pulse per output period
   output logic              freqlock
);
   import pll_pkg::*;

   localparam int ACCW = 2 * DIVW + 1;
   localparam int LCW  = $clog2(LOCK_CYCLES + 1);

   logic [ACCW-1:0] modulus;                            // divin * divout
   logic [ACCW-1:0] acc;
   logic [ACCW-1:0] acc_sum;
   logic [ACCW-1:0] acc_sub;
   logic            wrap;
   logic [LCW-1:0]  lock_cnt;
   logic            locked;

   //##################################################
   // tick accumulator
   //##################################################
   assign modulus = ACCW'(eff_div(cfg.divin)) * ACCW'(eff_div(cfg.divout));
   assign acc_sum = acc + ACCW'(eff_div(cfg.divfb));
   assign acc_sub = acc_sum - modulus;
   assign wrap    = (acc_sum >= modulus);

   always_ff @(posedge clk) begin
      if (rst || relock) begin
         acc <= '0;
      end else if (cfg.en) begin
         if (!wrap) begin
            acc <= acc_sum;
         end else if (acc_sub >= modulus) begin
            acc <= '0;                                  // divfb too big, cap at one per clk
         end else begin
            acc <= acc_sub;
         end
      end
   end

   // bypass passes the reference straight through
   assign tick = cfg.bypass | (cfg.en & wrap);

   //##################################################
   // lock timer
   //##################################################
   always_ff @(posedge clk) begin
      if (rst || relock || !cfg.en) begin
         lock_cnt <= '0;
         locked   <= 1'b0;
      end else if (!locked) begin
         lock_cnt <= lock_cnt + 1'b1;
         locked   <= (lock_cnt == LCW'(LOCK_CYCLES - 1));
      end
   end

   assign freqlock = cfg.en & (locked | cfg.bypass);    // bypass reports lock at once

endmodule

/* pll_cmd_decoder.sv */
// command FIFO with one credit returned per pop
// opcode decode into the config register
// relock pulse on frequency relevant writes
// read request toward the response unit, held off by rsp_ready
module pll_cmd_decoder #(
   parameter int CMD_DEPTH = 4                          // fifo slots, also sender credits
) (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     cmd_valid,          // sender spent a credit
   input  pll_pkg::pll_cmd_t        cmd,
   input  logic                     rsp_ready,          // response unit can take a read
   output logic                     cmd_credit,         // one pulse per pop
   output pll_pkg::pll_cfg_t        cfg,
   output logic                     relock,
   output logic                     rd_req,
   output logic [pll_pkg::TAGW-1:0] rd_tag
);
   import pll_pkg::*;

   localparam int PTRW  = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
   localparam int FILLW = $clog2(CMD_DEPTH + 1);

   pll_cmd_t         mem [CMD_DEPTH];                   // command storage
   logic [PTRW-1:0]  wr_ptr;
   logic [PTRW-1:0]  rd_ptr;
   logic [FILLW-1:0] fill;                              // entries held
   pll_cmd_t         head;
   logic             head_is_rd;
   logic             pop;
   dec_state_e       state;
   dec_state_e       state_nxt;
   pll_cfg_t         cfg_nxt;
   logic             relock_nxt;

   // wrap at depth, depth need not be a power of two
   function automatic logic [PTRW-1:0] ptr_inc(input logic [PTRW-1:0] p);
      return (p == PTRW'(CMD_DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   //##################################################
   // command fifo
   //##################################################
   always_ff @(posedge clk) begin
      if (cmd_valid) begin
         mem[wr_ptr] <= cmd;                            // credit guarantees a free slot
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill   <= '0;
      end else begin
         if (cmd_valid) begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         fill <= fill + FILLW'(cmd_valid) - FILLW'(pop);
      end
   end

   assign head       = mem[rd_ptr];
   assign head_is_rd = (head.op == OP_READ_STATUS);

   //##################################################
   // pop control
   //##################################################
   always_comb begin
      pop       = 1'b0;
      state_nxt = state;
      case (state)
         ST_IDLE: begin
            if (fill != '0) begin
               if (head_is_rd && !rsp_ready) begin
                  state_nxt = ST_WAIT_RSP;              // park until a credit shows up
               end else begin
                  pop = 1'b1;
               end
            end
         end
         ST_WAIT_RSP: begin
            if (rsp_ready) begin                        // head is still the read
               pop       = 1'b1;
               state_nxt = ST_IDLE;
            end
         end
         default: state_nxt = ST_IDLE;
      endcase
   end

   // opcode decode of the head entry
   always_comb begin
      cfg_nxt    = cfg;
      relock_nxt = 1'b0;
      case (head.op)
         OP_SET_DIVIN: begin
            cfg_nxt.divin = DIVW'(head.data);
            relock_nxt    = (DIVW'(head.data) != cfg.divin);
         end
         OP_SET_DIVFB: begin
            cfg_nxt.divfb = DIVW'(head.data);
            relock_nxt    = (DIVW'(head.data) != cfg.divfb);
         end
         OP_SET_DIVOUT: begin
            cfg_nxt.divout = DIVW'(head.data);
            relock_nxt     = (DIVW'(head.data) != cfg.divout);
         end
         OP_SET_CTRL: begin
            cfg_nxt.en     = head.data[0];
            cfg_nxt.bypass = head.data[1];
            relock_nxt     = head.data[0] & ~cfg.en;    // relock on enable rise only
         end
         default: ;                                     // nop, read, unused codes
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state      <= ST_IDLE;
         cfg        <= CFG_RESET;
         cmd_credit <= 1'b0;
         relock     <= 1'b0;
         rd_req     <= 1'b0;
      end else begin
         state      <= state_nxt;
         cmd_credit <= pop;                             // every pop frees a slot
         relock     <= pop & relock_nxt;
         rd_req     <= pop & head_is_rd;
         if (pop) begin
            cfg <= cfg_nxt;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (pop) begin
         rd_tag <= head.tag;                            // qualified by rd_req
      end
   end

endmodule

/* pll_freq_meter.sv */
// frequency meter on the pll tick stream
// counts ticks over a fixed window of clk cycles
// holds the last completed count, saturating
module pll_freq_meter #(
   parameter int WINDOW = 256                           // window length in clk cycles
) (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     tick,
   input  logic                     relock,             // realign window to new settings
   output logic [pll_pkg::CNTW-1:0] count
);
   import pll_pkg::*;

   localparam int WINW = (WINDOW > 1) ? $clog2(WINDOW) : 1;

   logic [WINW-1:0] win_cnt;                            // position inside window
   logic [CNTW-1:0] tick_cnt;                           // ticks so far this window
   logic [CNTW-1:0] tick_sum;
   logic            win_end;

   assign win_end  = (win_cnt == WINW'(WINDOW - 1));
   assign tick_sum = (&tick_cnt) ? tick_cnt : tick_cnt + CNTW'(tick);  // stick at max

   //##################################################
   // window and tick counters
   //##################################################
   always_ff @(posedge clk) begin
      if (rst) begin
         win_cnt  <= '0;
         tick_cnt <= '0;
         count    <= '0;
      end else if (relock) begin
         win_cnt  <= '0;                                // count keeps old result
         tick_cnt <= '0;
      end else if (win_end) begin
         count    <= tick_sum;                          // last cycle's tick included
         win_cnt  <= '0;
         tick_cnt <= '0;
      end else begin
         win_cnt  <= win_cnt + 1'b1;
         tick_cnt <= tick_sum;
      end
   end

endmodule

/* pll_pkg.sv */
// shared widths for the pll control subsystem
// opcode and decoder state enums
// command, config and response packet structs
// reset config and divider helper
package pll_pkg;

   //##################################################
   // widths
   //##################################################
   localparam int DIVW  = 8;                  // each divider
   localparam int CNTW  = 16;                 // measured tick count
   localparam int TAGW  = 8;                  // command tag echoed in response
   localparam int DATAW = 8;                  // command payload

   //##################################################
   // enums
   //##################################################
   typedef enum logic [2:0] {
      OP_NOP         = 3'd0,
      OP_SET_DIVIN   = 3'd1,                  // reference divider
      OP_SET_DIVFB   = 3'd2,                  // feedback divider
      OP_SET_DIVOUT  = 3'd3,                  // output divider
      OP_SET_CTRL    = 3'd4,                  // data[0] en, data[1] bypass
      OP_READ_STATUS = 3'd5                   // returns one response
   } pll_op_e;

   typedef enum logic {
      ST_IDLE,                                // popping freely
      ST_WAIT_RSP                             // read at head, no response credit
   } dec_state_e;

   //##################################################
   // packets
   //##################################################
   typedef struct packed {
      pll_op_e          op;
      logic [TAGW-1:0]  tag;
      logic [DATAW-1:0] data;
   } pll_cmd_t;                               // 19 bits

   typedef struct packed {
      logic [DIVW-1:0] divin;
      logic [DIVW-1:0] divfb;
      logic [DIVW-1:0] divout;
      logic            en;
      logic            bypass;
   } pll_cfg_t;                               // 26 bits

   typedef struct packed {
      logic [TAGW-1:0] tag;
      logic            freqlock;
      logic            en;
      logic            bypass;
      logic [CNTW-1:0] count;
   } pll_rsp_t;                               // 27 bits

   // dividers at 1, pll off
   localparam pll_cfg_t CFG_RESET = '{
      divin:  DIVW'(1),
      divfb:  DIVW'(1),
      divout: DIVW'(1),
      en:     1'b0,
      bypass: 1'b0
   };

   // zero divider acts as divide by one
   function automatic logic [DIVW-1:0] eff_div(input logic [DIVW-1:0] d);
      return (d == '0) ? DIVW'(1) : d;
   endfunction

endpackage

/* pll_status_resp.sv */
// response credit counter
// response packet builder merging lock, config and measured count
module pll_status_resp #(
   parameter int RSP_CREDITS = 2                        // credits owned after reset
) (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     rd_req,             // read popped by the decoder
   input  logic [pll_pkg::TAGW-1:0] rd_tag,
   input  logic                     freqlock,
   input  pll_pkg::pll_cfg_t        cfg,
   input  logic [pll_pkg::CNTW-1:0] count,
   input  logic                     rsp_credit,         // receiver freed one slot
   output logic                     rsp_ready,
   output logic                     rsp_valid,
   output pll_pkg::pll_rsp_t        rsp
);
   import pll_pkg::*;

   localparam int CRW = $clog2(RSP_CREDITS + 1);

   logic [CRW-1:0] credits;

   //##################################################
   // credit counter
   //##################################################
   // a read in flight already owns one of the credits
   assign rsp_ready = (credits > CRW'(rd_req));

   always_ff @(posedge clk) begin
      if (rst) begin
         credits   <= CRW'(RSP_CREDITS);
         rsp_valid <= 1'b0;
      end else begin
         credits   <= credits + CRW'(rsp_credit) - CRW'(rd_req);  // spend and return together
         rsp_valid <= rd_req;                           // one cycle after the request
      end
   end

   //##################################################
   // response packet
   //##################################################
   always_ff @(posedge clk) begin
      if (rd_req) begin
         rsp.tag      <= rd_tag;                        // echo the command tag
         rsp.freqlock <= freqlock;
         rsp.en       <= cfg.en;
         rsp.bypass   <= cfg.bypass;
         rsp.count    <= count;                         // last full window
      end
   end

endmodule

/* pll_subsys_top.sv */
// pll control and monitoring subsystem top level
// command decoder, pll model, frequency meter, response unit
module pll_subsys_top #(
   parameter int CMD_DEPTH   = 4,                       // command fifo and credits
   parameter int RSP_CREDITS = 2,                       // response credits
   parameter int LOCK_CYCLES = 32,                      // pll settling time
   parameter int WINDOW      = 256                      // meter window
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              cmd_valid,
   input  pll_pkg::pll_cmd_t cmd,
   output logic              cmd_credit,
   output logic              rsp_valid,
   output pll_pkg::pll_rsp_t rsp,
   input  logic              rsp_credit
);
   import pll_pkg::*;

   pll_cfg_t        cfg;                                // live pll settings
   logic            relock;
   logic            rd_req;
   logic [TAGW-1:0] rd_tag;
   logic            rsp_ready;
   logic            tick;
   logic            freqlock;
   logic [CNTW-1:0] count;

   //##################################################
   // control path
   //##################################################
   pll_cmd_decoder #(.CMD_DEPTH(CMD_DEPTH)) u_dec (
      .clk        (clk),
      .rst        (rst),
      .cmd_valid  (cmd_valid),
      .cmd        (cmd),
      .rsp_ready  (rsp_ready),
      .cmd_credit (cmd_credit),
      .cfg        (cfg),
      .relock     (relock),
      .rd_req     (rd_req),
      .rd_tag     (rd_tag)
   );

   //##################################################
   // pll and monitor
   //##################################################
   la_pll #(.LOCK_CYCLES(LOCK_CYCLES)) u_pll (
      .clk      (clk),
      .rst      (rst),
      .cfg      (cfg),
      .relock   (relock),
      .tick     (tick),
      .freqlock (freqlock)
   );

   pll_freq_meter #(.WINDOW(WINDOW)) u_meter (
      .clk    (clk),
      .rst    (rst),
      .tick   (tick),
      .relock (relock),                                 // same restart as the pll
      .count  (count)
   );

   pll_status_resp #(.RSP_CREDITS(RSP_CREDITS)) u_resp (
      .clk        (clk),
      .rst        (rst),
      .rd_req     (rd_req),
      .rd_tag     (rd_tag),
      .freqlock   (freqlock),
      .cfg        (cfg),
      .count      (count),
      .rsp_credit (rsp_credit),
      .rsp_ready  (rsp_ready),
      .rsp_valid  (rsp_valid),
      .rsp        (rsp)
   );

endmodule

/* tb_pll_subsys.sv */
// testbench for the pll control subsystem
// clock, reset, command credit model and response credit return
// compare tasks, watchdog and directed tests
module tb_pll_subsys;
   timeunit 1ns;
   timeprecision 1ps;
   import pll_pkg::*;

   localparam int CMD_DEPTH   = 4;
   localparam int RSP_CREDITS = 2;
   localparam int LOCK_CYCLES = 32;
   localparam int WINDOW      = 256;
   localparam int N_TESTS     = 13;                     // each divider set counts as one
   localparam int WD_CYCLES   = N_TESTS * (LOCK_CYCLES + 2 * WINDOW + 100);
   localparam int WAIT_LIMIT  = 64;                     // cycles for a credit or response

   logic            clk;
   logic            rst;
   logic            cmd_valid;
   pll_cmd_t        cmd;
   logic            cmd_credit;
   logic            rsp_valid;
   pll_rsp_t        rsp;
   logic            rsp_credit;

   int              cmd_credits;                        // sender side credit count
   int              owed;                               // response credits to hand back
   bit              rsp_hold;                           // withhold response credits
   pll_rsp_t        rsp_q [$];                          // responses in arrival order
   logic [TAGW-1:0] next_tag;
   integer          seed;

   pll_subsys_top #(
      .CMD_DEPTH   (CMD_DEPTH),
      .RSP_CREDITS (RSP_CREDITS),
      .LOCK_CYCLES (LOCK_CYCLES),
      .WINDOW      (WINDOW)
   ) uut (
      .clk        (clk),
      .rst        (rst),
      .cmd_valid  (cmd_valid),
      .cmd        (cmd),
      .cmd_credit (cmd_credit),
      .rsp_valid  (rsp_valid),
      .rsp        (rsp),
      .rsp_credit (rsp_credit)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;                            // 8 ns period
   end

   //##################################################
   // monitors and credit return
   //##################################################
   // flop outputs read at the rising edge hold the previous cycle's value
   always @(posedge clk) begin
      if (!rst) begin
         if (cmd_credit) cmd_credits++;                 // slot freed in the fifo
         if (rsp_valid) begin
            rsp_q.push_back(rsp);
            owed++;
         end
      end
   end

   always @(negedge clk) begin
      if (!rst && !rsp_hold && owed > 0) begin
         rsp_credit = 1'b1;                             // one credit per high cycle
         owed--;
      end else begin
         rsp_credit = 1'b0;
      end
   end

   //##################################################
   // failure reporting and compare tasks
   //##################################################
   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("SOME TESTS FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic value_error(input string sig, input int got, input int exp);
      fail_run($sformatf("ERR t=%0t %s got=%0d exp=%0d", $time, sig, got, exp));
   endtask

   task automatic check_int(input string sig, input int got, input int exp);
      if (got != exp) value_error(sig, got, exp);
   endtask

   task automatic check_count(input string sig, input logic [CNTW-1:0] got,
                              input logic [CNTW-1:0] exp);
      int diff;
      diff = int'(got) - int'(exp);
      if ($isunknown(got) || diff > 1 || diff < -1) value_error(sig, got, exp);
   endtask

   task automatic check_rsp(input pll_rsp_t got, input pll_rsp_t exp);
      if (got.tag !== exp.tag) value_error("rsp.tag", got.tag, exp.tag);
      if (got.freqlock !== exp.freqlock) value_error("rsp.freqlock", got.freqlock, exp.freqlock);
      if (got.en !== exp.en) value_error("rsp.en", got.en, exp.en);
      if (got.bypass !== exp.bypass) value_error("rsp.bypass", got.bypass, exp.bypass);
      check_count("rsp.count", got.count, exp.count);      // one tick either way
   endtask

   function automatic pll_rsp_t make_rsp(input logic [TAGW-1:0] tag, input logic lock,
                                         input logic en, input logic byp, input int cnt);
      pll_rsp_t r;
      r.tag      = tag;
      r.freqlock = lock;
      r.en       = en;
      r.bypass   = byp;
      r.count    = CNTW'(cnt);
      return r;
   endfunction

   // ticks per window from fout = fref * divfb / (divin * divout)
   function automatic int exp_count(input int divin, input int divfb, input int divout);
      int m;
      int f;
      m = ((divin == 0) ? 1 : divin) * ((divout == 0) ? 1 : divout);
      f = (divfb == 0) ? 1 : divfb;
      return (WINDOW * f) / m;
   endfunction

   //##################################################
   // command side tasks
   //##################################################
   task automatic idle(input int n);
      repeat (n) @(negedge clk);
   endtask

   task automatic send_cmd(input pll_op_e op, input logic [TAGW-1:0] tag,
                           input logic [DATAW-1:0] data);
      int waited;
      waited = 0;
      @(negedge clk);
      while (cmd_credits == 0) begin                    // stall without a credit
         if (waited == WAIT_LIMIT) fail_run("sender stalled, no command credit came back");
         waited++;
         @(negedge clk);
      end
      cmd.op      = op;
      cmd.tag     = tag;
      cmd.data    = data;
      cmd_valid   = 1'b1;
      cmd_credits--;
      @(negedge clk);
      cmd_valid   = 1'b0;
   endtask

   task automatic wait_rsp(output pll_rsp_t r);
      int waited;
      waited = 0;
      while (rsp_q.size() == 0) begin
         if (waited == WAIT_LIMIT) fail_run("no response arrived for a read command");
         waited++;
         @(negedge clk);
      end
      r = rsp_q.pop_front();
   endtask

   task automatic read_status(output pll_rsp_t r, output logic [TAGW-1:0] tag);
      tag = next_tag;
      next_tag++;
      send_cmd(OP_READ_STATUS, tag, '0);
      wait_rsp(r);
   endtask

   task automatic set_dividers(input int divin, input int divfb, input int divout);
      send_cmd(OP_SET_DIVIN, '0, DATAW'(divin));
      send_cmd(OP_SET_DIVFB, '0, DATAW'(divfb));
      send_cmd(OP_SET_DIVOUT, '0, DATAW'(divout));
   endtask

   task automatic set_ctrl(input logic en, input logic byp);
      send_cmd(OP_SET_CTRL, '0, {6'b0, byp, en});       // bit 0 en, bit 1 bypass
   endtask

   task automatic hold_rsp_credits(input bit h);
      @(posedge clk);                                   // away from the return process edge
      rsp_hold = h;
   endtask

   //##################################################
   // directed tests
   //##################################################
   task automatic reset_state();
      pll_rsp_t        r;
      logic [TAGW-1:0] t;
      read_status(r, t);
      check_rsp(r, make_rsp(t, 1'b0, 1'b0, 1'b0, 0));
   endtask

   task automatic lock_timing();
      pll_rsp_t        r;
      logic [TAGW-1:0] t;
      set_dividers(2, 1, 2);
      set_ctrl(1'b1, 1'b0);
      read_status(r, t);                                // well inside the settling time
      check_rsp(r, make_rsp(t, 1'b0, 1'b1, 1'b0, 0));
      idle(WINDOW + 10);
      read_status(r, t);
      check_rsp(r, make_rsp(t, 1'b1, 1'b1, 1'b0, exp_count(2, 1, 2)));
   endtask

   task automatic freq_point(input int divin, input int divfb, input int divout);
      pll_rsp_t        r;
      logic [TAGW-1:0] t;
      set_dividers(divin, divfb, divout);
      idle(WINDOW + 10);                                // one full window after relock
      read_status(r, t);
      check_rsp(r, make_rsp(t, 1'b1, 1'b1, 1'b0, exp_count(divin, divfb, divout)));
   endtask

   task automatic freq_rule();
      int divin;
      int divfb;
      int divout;
      freq_point(1, 1, 1);
      freq_point(2, 3, 4);
      freq_point(5, 7, 3);
      freq_point(10, 1, 1);
      freq_point(0, 3, 4);                              // zero divider acts as one
      repeat (3) begin
         divin  = 1 + ($unsigned($random(seed)) % 8);
         divout = 1 + ($unsigned($random(seed)) % 8);
         divfb  = 1 + ($unsigned($random(seed)) % (divin * divout));
         freq_point(divin, divfb, divout);
      end
   endtask

   task automatic bypass_and_disable();
      pll_rsp_t        r;
      logic [TAGW-1:0] t;
      set_ctrl(1'b1, 1'b1);                             // bypass alone does not relock
      idle(2 * WINDOW + 10);
      read_status(r, t);
      check_rsp(r, make_rsp(t, 1'b1, 1'b1, 1'b1, WINDOW));
      set_ctrl(1'b0, 1'b0);
      idle(2 * WINDOW + 10);
      read_status(r, t);
      check_rsp(r, make_rsp(t, 1'b0, 1'b0, 1'b0, 0));
   endtask

   task automatic credit_flow();
      pll_rsp_t r;
      idle(10);
      check_int("cmd_credits", cmd_credits, CMD_DEPTH);
      check_int("rsp_queue", rsp_q.size(), 0);
      hold_rsp_credits(1'b1);
      for (int i = 0; i < CMD_DEPTH; i++) begin
         send_cmd(OP_READ_STATUS, TAGW'(8'hA0 + i), '0);
      end
      idle(20);
      check_int("rsp_count", rsp_q.size(), RSP_CREDITS);   // only the credited reads
      check_int("cmd_credits", cmd_credits, RSP_CREDITS);
      idle(20);
      check_int("cmd_credits", cmd_credits, RSP_CREDITS);   // decoder stopped popping
      hold_rsp_credits(1'b0);
      for (int i = 0; i < CMD_DEPTH; i++) begin
         wait_rsp(r);
         check_rsp(r, make_rsp(TAGW'(8'hA0 + i), 1'b0, 1'b0, 1'b0, 0));
      end
      idle(20);
      check_int("cmd_credits", cmd_credits, CMD_DEPTH);
      check_int("rsp_queue", rsp_q.size(), 0);
   endtask

   //##################################################
   // main sequence and watchdog
   //##################################################
   initial begin
      rst         = 1'b1;
      cmd_valid   = 1'b0;
      cmd         = '0;
      rsp_credit  = 1'b0;
      rsp_hold    = 1'b0;
      cmd_credits = CMD_DEPTH;                          // sender owns every slot
      owed        = 0;
      next_tag    = 8'h10;
      seed        = 83;
      repeat (4) @(negedge clk);
      rst = 1'b0;
      reset_state();
      lock_timing();
      freq_rule();
      bypass_and_disable();
      credit_flow();
      $display("ALL TESTS PASSED");
      $finish;
   end

   initial begin
      repeat (WD_CYCLES) @(posedge clk);
      fail_run("run hung, watchdog ran out before the tests finished");
   end

endmodule
